//--- verif/core_patterns.txt
// group instr valid stall flush | expResultValid expAddr expData expFlags(NZCV)
// Outputs on a row belong to the instruction two rows earlier; group FF ends the file.
1 E3A01012 1 0 0  0 0 00000000 0
1 E2812005 1 0 0  0 0 00000000 0
1 E2423007 1 0 0  1 1 00000012 0
1 E2034030 1 0 0  1 2 00000017 0
1 E22450FF 1 0 0  1 3 00000010 0
1 E3856010 1 0 0  1 4 00000010 0
2 E1A07205 1 0 0  1 5 000000EF 0
2 E1A08226 1 0 0  1 6 000000FF 0
2 E2509001 1 0 0  1 7 00000EF0 0
2 E1A0A449 1 0 0  1 8 0000000F 0
2 E1A0B261 1 0 0  1 9 FFFFFFFF 8
2 E3520017 1 0 0  1 A FFFFFFFF 8
2 E053C002 1 0 0  1 B 20000001 8
3 E3510012 1 0 0  0 B 20000001 6
3 03A0D001 1 0 0  1 C FFFFFFF9 8
3 13A0D002 1 0 0  0 C FFFFFFF9 6
3 23A0E003 1 0 0  1 D 00000001 6
3 33A0E004 1 0 0  0 D 00000001 6
3 43A0F005 1 0 0  1 E 00000003 6
3 53A0F006 1 0 0  0 E 00000003 6
3 E08D000E 1 0 0  0 E 00000003 6
3 E1A0000F 1 0 0  1 F 00000006 6
4 E2811001 1 0 0  1 0 00000004 6
4 E0811001 1 0 0  1 0 00000006 6
4 E2412006 1 0 0  1 1 00000013 6
4 E0223001 1 0 0  1 1 00000026 6
5 E3A04011 1 0 0  1 2 00000020 6
5 E3A05022 1 1 0  1 3 00000006 6
5 E3A05022 1 1 0  0 3 00000006 6
5 E3A05022 1 0 0  0 3 00000006 6
5 E3A06033 1 0 0  1 4 00000011 6
5 E3A07044 1 0 1  1 5 00000022 6
5 E2870000 1 0 0  1 6 00000033 6
6 00000000 0 0 0  0 6 00000033 6
6 E2708055 1 0 0  1 0 00000EF0 6
6 E1A00008 1 0 0  0 0 00000EF0 6
6 00000000 0 0 0  0 0 00000EF0 6
6 00000000 0 0 0  1 0 0000000F 6
FF 0 0 0 0  0 0 0 0

//--- sim.f
+incdir+hw
hw/procTypes_pkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/deReg.sv
hw/execStage.sv
hw/dataPathCore.sv
verif/core_assert.sv
verif/coreTb.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module coreTb -f sim.f -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/VcoreTb)"; echo "$$out"; \
	echo "$$out" | grep -q "^All checks passed$$"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/coreTb.sv
`timescale 1ns/1ps

module coreTb import procTypes::*; ();

    localparam int WORDS_PER_ROW = 9;
    localparam int MAX_ROWS      = 64;
    localparam int RESET_LIMIT   = 20;

    logic        CLK;
    logic        Reset;
    logic [31:0] Instr;
    logic        InstrValid;
    logic        Stall;
    logic        Flush;
    logic        ResultValid;
    resultT      Result;
    flagsT       Flags;

    logic [31:0] patMem [0:WORDS_PER_ROW*MAX_ROWS-1];

    int checkCount;
    int errorCount;
    int groupChecks;
    int groupErrors;

    dataPathCore i_dut (
        .CLK         (CLK),
        .Reset       (Reset),
        .Instr       (Instr),
        .InstrValid  (InstrValid),
        .Stall       (Stall),
        .Flush       (Flush),
        .ResultValid (ResultValid),
        .Result      (Result),
        .Flags       (Flags)
    );

    always #10 CLK = ~CLK;

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic compareBit(input logic got, input logic exp, input string what);
        checkCount++;
        groupChecks++;
        if (got !== exp) begin
            errorCount++;
            groupErrors++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compareResult(input resultT got, input resultT exp);
        checkCount++;
        groupChecks++;
        if (got !== exp) begin
            errorCount++;
            groupErrors++;
            $display("[FAIL] %0t ns: Result is R%0d=%h, expected R%0d=%h",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic compareFlags(input flagsT got, input flagsT exp);
        checkCount++;
        groupChecks++;
        if (got !== exp) begin
            errorCount++;
            groupErrors++;
            $display("[FAIL] %0t ns: Flags NZCV is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic reportGroup(input int grp);
        $display("Test group %0d: %0d checks, %0d errors", grp, groupChecks, groupErrors);
        groupChecks = 0;
        groupErrors = 0;
    endtask

    // Reset is released a little after an edge, ahead of the stimulus slot.
    initial begin
        Reset = 1'b1;
        repeat (4) @(posedge CLK);
        #1 Reset = 1'b0;
    end

    initial begin
        int          base;
        int          curGroup;
        int          waitCount;
        int          assertFails;
        bit          finished;
        resultT      expResult;
        flagsT       expFlags;

        CLK         = 1'b0;
        Instr       = '0;
        InstrValid  = 1'b0;
        Stall       = 1'b0;
        Flush       = 1'b0;
        checkCount  = 0;
        errorCount  = 0;
        groupChecks = 0;
        groupErrors = 0;
        finished    = 1'b0;
        $readmemh("verif/core_patterns.txt", patMem);

        // Outputs must stay cleared for as long as reset is held.
        waitCount = 0;
        do begin
            @(posedge CLK);
            #2;
            if (Reset) begin
                compareBit(ResultValid, 1'b0, "ResultValid during reset");
                compareFlags(Flags, '0);
            end
            waitCount++;
        end while (Reset && waitCount < RESET_LIMIT);

        if (Reset) begin
            errorCount++;
            $display("Reset was never released, gave up after %0d cycles", RESET_LIMIT);
        end else begin
            reportGroup(0);
            curGroup = 1;
            for (int row = 0; row < MAX_ROWS && !finished; row++) begin
                base = row * WORDS_PER_ROW;
                if (patMem[base] === 'x) begin
                    errorCount++;
                    $display("Pattern file ran out at row %0d before its end marker", row);
                    finished = 1'b1;
                end else if (patMem[base] == 32'hFF) begin
                    reportGroup(curGroup);
                    finished = 1'b1;
                end else begin
                    if (patMem[base] != curGroup) begin
                        reportGroup(curGroup);
                        curGroup = patMem[base];
                    end
                    Instr      = patMem[base+1];
                    InstrValid = patMem[base+2][0];
                    Stall      = patMem[base+3][0];
                    Flush      = patMem[base+4][0];
                    expResult.addr = patMem[base+6][3:0];
                    expResult.data = patMem[base+7];
                    expFlags       = flagsT'(patMem[base+8][3:0]);

                    // Sample one nanosecond before the next rising edge.
                    #17;
                    compareBit(ResultValid, patMem[base+5][0], "ResultValid");
                    compareResult(Result, expResult);
                    compareFlags(Flags, expFlags);
                    @(posedge CLK);
                    #2;
                end
            end
            if (!finished) begin
                errorCount++;
                $display("No end marker within %0d pattern rows", MAX_ROWS);
            end
        end

        // Failed assertions in the bound checker count as errors too.
        assertFails = i_dut.i_coreAssert.failCount;
        errorCount += assertFails;

        $display("Total: %0d checks, %0d errors, %0d of them from assertions",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verif/core_assert.sv
`timescale 1ns/1ps

module coreAssert import procTypes::*; (
    input logic    CLK,
    input logic    Reset,
    input logic    Stall,
    input logic    Flush,
    input decodedT decodedE,
    input logic    ResultValid
);

    int failCount = 0;

    ////////////////////////////////////////
    // Pipeline register control
    ////////////////////////////////////////

    // A flushed slot becomes a bubble.
    flushBubble: assert property (@(posedge CLK) disable iff (Reset)
        Flush |=> !decodedE.valid)
        else begin
            $error("deReg still valid after flush");
            failCount++;
        end

    stallHold: assert property (@(posedge CLK) disable iff (Reset)
        (Stall && !Flush) |=> $stable(decodedE))
        else begin
            $error("deReg changed during stall");
            failCount++;
        end

    resetQuiet: assert property (@(posedge CLK)
        Reset |-> !ResultValid)
        else begin
            $error("ResultValid high during reset");
            failCount++;
        end

endmodule

bind dataPathCore coreAssert i_coreAssert (
    .CLK         (CLK),
    .Reset       (Reset),
    .Stall       (Stall),
    .Flush       (Flush),
    .decodedE    (decodedE),
    .ResultValid (ResultValid)
);

//--- hw/dataPathCore.sv
`timescale 1ns/1ps
`include "proc_params.svh"

module dataPathCore import procTypes::*; (
    input  logic        CLK,
    input  logic        Reset,
    input  logic [31:0] Instr,
    input  logic        InstrValid,
    input  logic        Stall,
    input  logic        Flush,
    output logic        ResultValid,
    output resultT      Result,
    output flagsT       Flags
);

    logic [`REG_ADDR_WIDTH-1:0] raA;
    logic [`REG_ADDR_WIDTH-1:0] raB;
    logic [`DATA_WIDTH-1:0]     rdA;
    logic [`DATA_WIDTH-1:0]     rdB;
    logic                       wrEn;
    logic [`REG_ADDR_WIDTH-1:0] wrAddr;
    logic [`DATA_WIDTH-1:0]     wrData;
    decodedT                    decodedD;
    decodedT                    decodedE;

    ////////////////////////////////////////
    // Decode stage
    ////////////////////////////////////////

    instrDecoder i_decoder (
        .Instr      (Instr),
        .InstrValid (InstrValid),
        .raA        (raA),
        .raB        (raB),
        .rdA        (rdA),
        .rdB        (rdB),
        .decodedD   (decodedD)
    );

    // Write port comes back from execute; the bypass closes the loop.
    regFile i_regFile (
        .CLK    (CLK),
        .Reset  (Reset),
        .raA    (raA),
        .raB    (raB),
        .rdA    (rdA),
        .rdB    (rdB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    deReg i_deReg (
        .CLK      (CLK),
        .Reset    (Reset),
        .Stall    (Stall),
        .Flush    (Flush),
        .decodedD (decodedD),
        .decodedE (decodedE)
    );

    ////////////////////////////////////////
    // Execute stage
    ////////////////////////////////////////

    execStage i_execStage (
        .CLK         (CLK),
        .Reset       (Reset),
        .Stall       (Stall),
        .decodedE    (decodedE),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .ResultValid (ResultValid),
        .Result      (Result),
        .Flags       (Flags)
    );

endmodule

//--- hw/execStage.sv
`timescale 1ns/1ps
`include "proc_params.svh"

module execStage import procTypes::*; (
    input  logic                       CLK,
    input  logic                       Reset,
    input  logic                       Stall,
    input  decodedT                    decodedE,
    output logic                       wrEn,
    output logic [`REG_ADDR_WIDTH-1:0] wrAddr,
    output logic [`DATA_WIDTH-1:0]     wrData,
    output logic                       ResultValid,
    output resultT                     Result,
    output flagsT                      Flags
);

    logic [`DATA_WIDTH-1:0]   opA;
    logic [`DATA_WIDTH-1:0]   opB;
    logic [`DATA_WIDTH-1:0]   aluOut;
    logic [`DATA_WIDTH:0]     lslTmp;
    logic [`DATA_WIDTH:0]     lsrTmp;
    logic [`DATA_WIDTH:0]     asrTmp;
    logic [2*`DATA_WIDTH-1:0] rorTmp;
    logic [`DATA_WIDTH:0]     addTmp;
    logic [`DATA_WIDTH:0]     subTmp;
    logic                     shiftCarry;
    flagsT                    aluFlags;
    logic                     condPass;
    logic                     commit;
    logic                     flagWrite;

    ////////////////////////////////////////
    // Operand B shifter
    ////////////////////////////////////////

    assign opA = decodedE.srcA;

    always_comb begin
        // The extra bit on each side catches the last bit shifted out.
        lslTmp = {1'b0, decodedE.srcB} << decodedE.shamt;
        lsrTmp = {decodedE.srcB, 1'b0} >> decodedE.shamt;
        asrTmp = $signed({decodedE.srcB, 1'b0}) >>> decodedE.shamt;
        rorTmp = {decodedE.srcB, decodedE.srcB} >> decodedE.shamt;

        opB        = decodedE.srcB;
        shiftCarry = Flags.c;
        if (decodedE.useImm) begin
            opB = {{(`DATA_WIDTH-8){1'b0}}, decodedE.imm8};
        end else if (decodedE.shamt != 5'd0) begin
            case (decodedE.shiftType)
                SH_LSL: begin
                    opB        = lslTmp[`DATA_WIDTH-1:0];
                    shiftCarry = lslTmp[`DATA_WIDTH];
                end
                SH_LSR: begin
                    opB        = lsrTmp[`DATA_WIDTH:1];
                    shiftCarry = lsrTmp[0];
                end
                SH_ASR: begin
                    opB        = asrTmp[`DATA_WIDTH:1];
                    shiftCarry = asrTmp[0];
                end
                default: begin
                    opB        = rorTmp[`DATA_WIDTH-1:0];
                    shiftCarry = rorTmp[`DATA_WIDTH-1];
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        addTmp = {1'b0, opA} + {1'b0, opB};
        // Subtraction as A + ~B + 1, so the carry out is the inverted borrow.
        subTmp = {1'b0, opA} + {1'b0, ~opB} + {{`DATA_WIDTH{1'b0}}, 1'b1};

        aluFlags.c = shiftCarry;
        aluFlags.v = Flags.v;
        case (decodedE.aluOp)
            OP_AND: aluOut = opA & opB;
            OP_EOR: aluOut = opA ^ opB;
            OP_ORR: aluOut = opA | opB;
            OP_ADD: begin
                aluOut     = addTmp[`DATA_WIDTH-1:0];
                aluFlags.c = addTmp[`DATA_WIDTH];
                aluFlags.v = (opA[`DATA_WIDTH-1] == opB[`DATA_WIDTH-1]) &&
                             (aluOut[`DATA_WIDTH-1] != opA[`DATA_WIDTH-1]);
            end
            OP_SUB, OP_CMP: begin
                aluOut     = subTmp[`DATA_WIDTH-1:0];
                aluFlags.c = subTmp[`DATA_WIDTH];
                aluFlags.v = (opA[`DATA_WIDTH-1] != opB[`DATA_WIDTH-1]) &&
                             (aluOut[`DATA_WIDTH-1] != opA[`DATA_WIDTH-1]);
            end
            default: aluOut = opB;
        endcase
        aluFlags.n = aluOut[`DATA_WIDTH-1];
        aluFlags.z = (aluOut == '0);
    end

    ////////////////////////////////////////
    // Condition check and commit
    ////////////////////////////////////////

    always_comb begin
        case (decodedE.cond)
            COND_EQ: condPass = Flags.z;
            COND_NE: condPass = !Flags.z;
            COND_CS: condPass = Flags.c;
            COND_CC: condPass = !Flags.c;
            COND_MI: condPass = Flags.n;
            COND_PL: condPass = !Flags.n;
            COND_VS: condPass = Flags.v;
            COND_VC: condPass = !Flags.v;
            COND_AL: condPass = 1'b1;
            default: condPass = 1'b0;
        endcase
    end

    // Stall freezes the whole slice, so nothing commits while it is high.
    assign commit    = decodedE.valid && condPass && !Stall;
    assign flagWrite = commit && (decodedE.setFlags || (decodedE.aluOp == OP_CMP));

    assign wrEn   = commit && decodedE.regWrite;
    assign wrAddr = decodedE.destAddr;
    assign wrData = aluOut;

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            ResultValid <= 1'b0;
            Result      <= '0;
            Flags       <= '0;
        end else begin
            ResultValid <= wrEn;
            if (wrEn) begin
                Result.addr <= wrAddr;
                Result.data <= wrData;
            end
            if (flagWrite) begin
                Flags <= aluFlags;
            end
        end
    end

endmodule

//--- hw/deReg.sv
`timescale 1ns/1ps

module deReg import procTypes::*; (
    input  logic    CLK,
    input  logic    Reset,
    input  logic    Stall,
    input  logic    Flush,
    input  decodedT decodedD,
    output decodedT decodedE
);

    // Priority is reset, flush, stall, then load.
    // A flush leaves a bubble and drops whatever decode offered this cycle.
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            decodedE <= '0;
        end else if (Flush) begin
            decodedE <= '0;
        end else if (!Stall) begin
            decodedE <= decodedD;
        end
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps
`include "proc_params.svh"

module regFile (
    input  logic                       CLK,
    input  logic                       Reset,
    input  logic [`REG_ADDR_WIDTH-1:0] raA,
    input  logic [`REG_ADDR_WIDTH-1:0] raB,
    output logic [`DATA_WIDTH-1:0]     rdA,
    output logic [`DATA_WIDTH-1:0]     rdB,
    input  logic                       wrEn,
    input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
    input  logic [`DATA_WIDTH-1:0]     wrData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // A write landing at the coming edge is forwarded to the reader, so the
    // instruction in decode sees the value its predecessor is committing.
    assign rdA = (wrEn && (wrAddr == raA)) ? wrData : regs[raA];
    assign rdB = (wrEn && (wrAddr == raB)) ? wrData : regs[raB];

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ps
`include "proc_params.svh"

module instrDecoder import procTypes::*; (
    input  logic [31:0]                Instr,
    input  logic                       InstrValid,
    output logic [`REG_ADDR_WIDTH-1:0] raA,
    output logic [`REG_ADDR_WIDTH-1:0] raB,
    input  logic [`DATA_WIDTH-1:0]     rdA,
    input  logic [`DATA_WIDTH-1:0]     rdB,
    output decodedT                    decodedD
);

    logic [3:0] opField;
    logic       isDataProc;
    logic       opKnown;

    ////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////

    assign opField    = Instr[24:21];
    assign isDataProc = (Instr[27:26] == 2'b00);

    // Rn feeds operand A, Rm feeds operand B.
    assign raA = Instr[19:16];
    assign raB = Instr[3:0];

    always_comb begin
        case (opField)
            OP_AND, OP_EOR, OP_SUB, OP_ADD, OP_ORR, OP_MOV, OP_CMP: begin
                opKnown = isDataProc;
            end
            default: begin
                opKnown = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // Bundle assembly
    ////////////////////////////////////////

    always_comb begin
        decodedD.valid = InstrValid;
        decodedD.cond  = condE'(Instr[31:28]);

        // An unknown opcode still travels down the pipe, but with no
        // register write and no flag write it leaves no trace.
        if (opKnown) begin
            decodedD.aluOp    = aluOpE'(opField);
            decodedD.setFlags = Instr[20];
            decodedD.regWrite = (opField != OP_CMP);
        end else begin
            decodedD.aluOp    = OP_AND;
            decodedD.setFlags = 1'b0;
            decodedD.regWrite = 1'b0;
        end

        decodedD.destAddr = Instr[15:12];
        decodedD.srcA     = rdA;
        decodedD.srcB     = rdB;

        // Immediate form uses imm8 zero-extended, no rotation.
        decodedD.useImm    = Instr[25];
        decodedD.imm8      = Instr[7:0];
        decodedD.shiftType = shiftE'(Instr[6:5]);
        decodedD.shamt     = Instr[11:7];
    end

endmodule

//--- hw/procTypes_pkg.sv
`include "proc_params.svh"

package procTypes;

    ////////////////////////////////////////
    // Instruction field encodings
    ////////////////////////////////////////

    // Data-processing opcodes, bits 24..21 of the instruction.
    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_CMP = 4'b1010,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101
    } aluOpE;

    // Condition field, bits 31..28.
    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_CS = 4'b0010,
        COND_CC = 4'b0011,
        COND_MI = 4'b0100,
        COND_PL = 4'b0101,
        COND_VS = 4'b0110,
        COND_VC = 4'b0111,
        COND_AL = 4'b1110
    } condE;

    typedef enum logic [1:0] {
        SH_LSL = 2'b00,
        SH_LSR = 2'b01,
        SH_ASR = 2'b10,
        SH_ROR = 2'b11
    } shiftE;

    ////////////////////////////////////////
    // Pipeline bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    typedef struct packed {
        logic                       valid;
        condE                       cond;
        aluOpE                      aluOp;
        logic                       setFlags;
        logic                       regWrite;
        logic [`REG_ADDR_WIDTH-1:0] destAddr;
        logic [`DATA_WIDTH-1:0]     srcA;
        logic [`DATA_WIDTH-1:0]     srcB;
        logic                       useImm;
        logic [7:0]                 imm8;
        shiftE                      shiftType;
        logic [4:0]                 shamt;
    } decodedT;

    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]     data;
    } resultT;

endpackage

//--- hw/proc_params.svh
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Operand, result and register width.
`define DATA_WIDTH 32

// The instruction format has 4-bit register fields, so the register file is
// fixed at sixteen entries.
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

`endif
